// File: sim.f
+incdir+include
hw/strm_pkg.sv
hw/strm_fifo.sv
hw/strm_addr_gen.sv
hw/strm_source.sv
hw/strm_top.sv
verif/tb_strm_mem.sv
verif/tb_strm_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the streamer testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  -f sim.f --top-module tb_strm_top -o tb_strm_top > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/tb_strm_top > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$SIM_LOG"; then
  echo "failure reported, see $SIM_LOG"
  exit 1
fi
echo "no failure reported in $SIM_LOG"
exit 0

// File: verif/tb_strm_top.sv
/*
 * testbench for strm_top
 * clock, reset, pattern runs, checking assertions, timeout and report
 */

module tb_strm_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TESTS = 6;                        // tests in the run
  localparam int BEATS = 117;                      // beats expected over all tests
  localparam int LIMIT = 40 * BEATS + 200 * TESTS;

  logic                clk, rst_n, clear, start;
  logic                stream_ready = 1'b1;
  int                  rdy_mode = 0;               // 0 ready, 1 random, 2 stalled
  strm_pkg::addr_t     base;
  strm_pkg::len_t      word_stride, line_len, line_stride, line_cnt;
  logic                ready_start, done, mem_req, mem_gnt, mem_rvalid, mem_rready;
  strm_pkg::addr_t     mem_addr;
  strm_pkg::mem_data_t mem_rdata;
  logic                stream_valid, beat, busy_q;
  strm_pkg::beat_t     stream_data, exp_head;
  logic [31:0]         exp_mem [256];              // ring of expected beats
  int unsigned         exp_wr, exp_rd;
  int                  err_cnt, test_cnt, bad_tests, cyc, errs, mark;

  strm_top UUT (
    .clk_i (clk), .rst_ni (rst_n), .clear_i (clear), .start_i (start),
    .base_i (base), .word_stride_i (word_stride), .line_len_i (line_len),
    .line_stride_i (line_stride), .line_cnt_i (line_cnt),
    .ready_start_o (ready_start), .done_o (done),
    .mem_req_o (mem_req), .mem_addr_o (mem_addr), .mem_gnt_i (mem_gnt),
    .mem_rvalid_i (mem_rvalid), .mem_rdata_i (mem_rdata), .mem_rready_o (mem_rready),
    .stream_valid_o (stream_valid), .stream_data_o (stream_data),
    .stream_ready_i (stream_ready)
  );

  tb_strm_mem i_mem (
    .clk_i (clk), .rst_ni (rst_n), .clear_i (clear), .mem_req_i (mem_req),
    .mem_addr_i (mem_addr), .mem_gnt_o (mem_gnt), .mem_rvalid_o (mem_rvalid),
    .mem_rdata_o (mem_rdata), .mem_rready_i (mem_rready)
  );

  always #2 clk = ~clk;

  always @(negedge clk) begin
    case (rdy_mode)
      0:       stream_ready = 1'b1;
      1:       stream_ready = 1'($urandom % 2);
      default: stream_ready = 1'b0;
    endcase
  end

  assign beat     = stream_valid && stream_ready;
  assign exp_head = exp_mem[exp_rd[7:0]];

  // a run ends on done or clear
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      exp_rd <= 0;
    end else begin
      if (clear || done) busy_q <= 1'b0;
      else if (start && ready_start) busy_q <= 1'b1;
      if (clear) exp_rd <= exp_wr;                 // aborted beats are dropped
      else if (beat) exp_rd <= exp_rd + 1;
    end
  end

  a_beat_data: assert property (@(posedge clk) disable iff (!rst_n)
    beat |-> exp_rd != exp_wr && stream_data == exp_head)
    else begin
      err_cnt++;
      $display("ERR %0t: beat 0x%08h, expected 0x%08h", $time, $sampled(stream_data),
               $sampled(exp_head));
    end
  a_beat_hold: assert property (@(posedge clk) disable iff (!rst_n)
    stream_valid && !stream_ready && !clear |=> stream_valid && $stable(stream_data))
    else begin
      err_cnt++;
      $display("ERR %0t: held beat dropped or changed", $time);
    end
  a_req_rules: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req |-> stream_ready && mem_addr[1:0] == 2'b00)
    else begin
      err_cnt++;
      $display("ERR %0t: request under back-pressure or not word aligned", $time);
    end
  a_done_once: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> busy_q && exp_rd == exp_wr)
    else begin
      err_cnt++;
      $display("ERR %0t: done_o before the last beat or repeated", $time);
    end
  a_ready_after_done: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> ready_start)
    else begin
      err_cnt++;
      $display("ERR %0t: ready_start_o low after done_o", $time);
    end
  a_busy_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
    busy_q |-> !ready_start)
    else begin
      err_cnt++;
      $display("ERR %0t: ready_start_o high during a run", $time);
    end
  a_clear_idle: assert property (@(posedge clk) disable iff (!rst_n)
    clear |=> ready_start && !stream_valid)
    else begin
      err_cnt++;
      $display("ERR %0t: DUT not idle after clear_i", $time);
    end

  function automatic logic [7:0] expected_byte(strm_pkg::addr_t a);
    return 8'(a * 32'd7) + 8'd1;
  endfunction

  // four bytes from each generated address
  task automatic build_expected(input strm_pkg::addr_t b, input strm_pkg::len_t ws,
                                input strm_pkg::len_t ll, input strm_pkg::len_t ls,
                                input strm_pkg::len_t lc);
    strm_pkg::addr_t a;
    for (int l = 0; l < lc; l++) begin
      for (int w = 0; w < ll; w++) begin
        a = b + 32'(l) * 32'(ls) + 32'(w) * 32'(ws);
        exp_mem[exp_wr[7:0]] = {expected_byte(a + 3), expected_byte(a + 2),
                                expected_byte(a + 1), expected_byte(a)};
        exp_wr++;
      end
    end
  endtask

  task automatic start_run(input strm_pkg::addr_t b, input strm_pkg::len_t ws,
                           input strm_pkg::len_t ll, input strm_pkg::len_t ls,
                           input strm_pkg::len_t lc);
    @(negedge clk);
    while (!ready_start) @(negedge clk);
    build_expected(b, ws, ll, ls, lc);             // previous done already retired
    base        = b;
    word_stride = ws;
    line_len    = ll;
    line_stride = ls;
    line_cnt    = lc;
    start       = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_done();
    do @(negedge clk); while (!done);
  endtask

  task automatic apply_clear();
    rdy_mode = 2;                                  // no beat or issue on the clear edge
    @(negedge clk);
    clear = 1'b1;
    @(negedge clk);
    clear    = 1'b0;
    rdy_mode = 0;
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt != errs_before) begin
      bad_tests++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
    end else begin
      $display("test %0d %s: ok", test_cnt, name);
    end
  endtask

  initial begin
    cyc = 0;
    while (cyc < LIMIT) begin
      @(posedge clk);
      cyc++;
    end
    $display("timeout after %0d cycles, the DUT did not finish its runs", cyc);
    $display("Test failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h0a23_3196));
    clk = 1'b0;
    rst_n = 1'b0;
    clear = 1'b0;
    start = 1'b0;
    base = '0;
    word_stride = '0;
    line_len = '0;
    line_stride = '0;
    line_cnt = '0;
    exp_wr = 0;
    err_cnt = 0;
    test_cnt = 0;
    bad_tests = 0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    errs = err_cnt;
    start_run(32'h100, 16'd4, 16'd16, 16'd0, 16'd1);
    wait_done();
    report_test("aligned burst", errs);

    errs = err_cnt;
    start_run(32'h201, 16'd4, 16'd4, 16'd0, 16'd1);
    wait_done();
    start_run(32'h302, 16'd4, 16'd4, 16'd0, 16'd1);
    wait_done();
    start_run(32'h403, 16'd4, 16'd4, 16'd0, 16'd1);
    wait_done();
    report_test("misaligned bases", errs);

    errs = err_cnt;
    start_run(32'h501, 16'd4, 16'd5, 16'h46, 16'd3); // line stride not word multiple
    wait_done();
    report_test("two-level pattern", errs);

    errs = err_cnt;
    rdy_mode = 1;
    start_run(32'h603, 16'd4, 16'd8, 16'h45, 16'd3);
    wait_done();
    rdy_mode = 0;
    report_test("back-pressure", errs);

    errs = err_cnt;
    start_run(32'h700, 16'd4, 16'd8, 16'd0, 16'd1);
    repeat (2) @(negedge clk);
    start = 1'b1;                                  // second start with the same config
    repeat (2) @(negedge clk);
    start = 1'b0;
    wait_done();
    report_test("start while busy", errs);

    errs = err_cnt;
    mark = exp_wr;
    rdy_mode = 1;
    start_run(32'h802, 16'd4, 16'd8, 16'h40, 16'd4);
    while (exp_rd < mark + 5) @(negedge clk);
    apply_clear();
    start_run(32'h901, 16'd8, 16'd5, 16'h2b, 16'd2);
    wait_done();
    report_test("clear", errs);

    $display("tests %0d, tests with errors %0d, failed checks %0d",
             test_cnt, bad_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verif/tb_strm_mem.sv
/*
 * memory model for the streamer read port
 * random grant, in-order responses after 1 to 6 cycles, held until accepted
 */

`include "strm_cfg.svh"

module tb_strm_mem (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,      // drops reads in flight
  input  logic                mem_req_i,
  input  strm_pkg::addr_t     mem_addr_i,   // word aligned
  output logic                mem_gnt_o,
  output logic                mem_rvalid_o,
  output strm_pkg::mem_data_t mem_rdata_o,
  input  logic                mem_rready_i
);
  timeunit 1ns;
  timeprecision 100ps;

  strm_pkg::addr_t     pend_addr [$];       // accepted reads, oldest first
  int unsigned         pend_due [$];        // cycle the response may show
  int unsigned         cyc;
  logic                gnt = 1'b0;
  logic                rvalid = 1'b0;
  strm_pkg::mem_data_t rdata = '0;

  assign mem_gnt_o    = gnt;
  assign mem_rvalid_o = rvalid;
  assign mem_rdata_o  = rdata;

  // byte k of the line is mem[a + k], mem[x] = low byte of 7x, plus 1
  function automatic strm_pkg::mem_data_t line_data(strm_pkg::addr_t a);
    strm_pkg::mem_data_t d;
    for (int k = 0; k < 8; k++) begin
      d[8*k +: 8] = 8'((a + 32'(k)) * 32'd7) + 8'd1;
    end
    return d;
  endfunction

  // bookkeeping on the edge where the DUT samples
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_addr.delete();
      pend_due.delete();
      cyc = 0;
    end else begin
      cyc++;
      if (clear_i) begin
        pend_addr.delete();               // flushed with the offset FIFO
        pend_due.delete();
      end else begin
        if (rvalid && mem_rready_i) begin
          void'(pend_addr.pop_front());   // response consumed
          void'(pend_due.pop_front());
        end
        if (mem_req_i && gnt) begin
          pend_addr.push_back(mem_addr_i);
          pend_due.push_back(cyc + 1 + ($urandom % 6)); // 1..6 cycles
        end
      end
    end
  end

  // outputs change on the falling edge only
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      gnt    = 1'b0;
      rvalid = 1'b0;
    end else begin
      gnt = (($urandom % 4) != 0) && (pend_addr.size() < `STRM_OFS_DEPTH);
      if (pend_addr.size() > 0 && pend_due[0] <= cyc + 1) begin
        rvalid = 1'b1;                    // head stays until popped
        rdata  = line_data(pend_addr[0]);
      end else begin
        rvalid = 1'b0;
      end
    end
  end

endmodule

// File: hw/strm_top.sv
/*
 * streamer top level
 * address generator, address FIFO, offset FIFO, source core
 */

`include "strm_cfg.svh"

module strm_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  logic                start_i,
  input  strm_pkg::addr_t     base_i,
  input  strm_pkg::len_t      word_stride_i,
  input  strm_pkg::len_t      line_len_i,
  input  strm_pkg::len_t      line_stride_i,
  input  strm_pkg::len_t      line_cnt_i,
  output logic                ready_start_o,
  output logic                done_o,
  output logic                mem_req_o,
  output strm_pkg::addr_t     mem_addr_o,
  input  logic                mem_gnt_i,
  input  logic                mem_rvalid_i,
  input  strm_pkg::mem_data_t mem_rdata_i,
  output logic                mem_rready_o,
  output logic                stream_valid_o,
  output strm_pkg::beat_t     stream_data_o,
  input  logic                stream_ready_i
);

  logic            gen_start, gen_done;
  logic            gen_valid, gen_ready;     // generator -> addr FIFO
  strm_pkg::addr_t gen_addr;
  logic            head_valid, head_ready;   // addr FIFO -> core
  strm_pkg::addr_t head_addr;
  logic            addr_fifo_empty;
  logic            ofs_push, ofs_ready, ofs_valid, ofs_pop;
  strm_pkg::ofs_t  ofs_push_data, ofs_head;

  strm_addr_gen i_addr_gen (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .start_i       ( gen_start     ),
    .base_i        ( base_i        ),
    .word_stride_i ( word_stride_i ),
    .line_len_i    ( line_len_i    ),
    .line_stride_i ( line_stride_i ),
    .line_cnt_i    ( line_cnt_i    ),
    .addr_ready_i  ( gen_ready     ),
    .addr_valid_o  ( gen_valid     ),
    .addr_o        ( gen_addr      ),
    .done_o        ( gen_done      )
  );

  strm_fifo #(
    .WIDTH ( `STRM_ADDR_W          ),
    .DEPTH ( `STRM_ADDR_FIFO_DEPTH )
  ) i_addr_fifo (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .clear_i      ( clear_i         ),
    .push_valid_i ( gen_valid       ),
    .push_data_i  ( gen_addr        ),
    .push_ready_o ( gen_ready       ),
    .pop_valid_o  ( head_valid      ),
    .pop_data_o   ( head_addr       ),
    .pop_ready_i  ( head_ready      ),
    .empty_o      ( addr_fifo_empty )
  );

  // one entry per read in flight
  strm_fifo #(
    .WIDTH ( 2               ),
    .DEPTH ( `STRM_OFS_DEPTH )
  ) i_ofs_fifo (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .clear_i      ( clear_i       ),
    .push_valid_i ( ofs_push      ),
    .push_data_i  ( ofs_push_data ),
    .push_ready_o ( ofs_ready     ),
    .pop_valid_o  ( ofs_valid     ),
    .pop_data_o   ( ofs_head      ),
    .pop_ready_i  ( ofs_pop       ),
    .empty_o      (               )
  );

  strm_source i_source (
    .clk_i             ( clk_i           ),
    .rst_ni            ( rst_ni          ),
    .clear_i           ( clear_i         ),
    .start_i           ( start_i         ),
    .line_len_i        ( line_len_i      ),
    .line_cnt_i        ( line_cnt_i      ),
    .gen_done_i        ( gen_done        ),
    .addr_valid_i      ( head_valid      ),
    .addr_i            ( head_addr       ),
    .addr_fifo_empty_i ( addr_fifo_empty ),
    .ofs_ready_i       ( ofs_ready       ),
    .ofs_valid_i       ( ofs_valid       ),
    .ofs_i             ( ofs_head        ),
    .mem_gnt_i         ( mem_gnt_i       ),
    .mem_rvalid_i      ( mem_rvalid_i    ),
    .mem_rdata_i       ( mem_rdata_i     ),
    .stream_ready_i    ( stream_ready_i  ),
    .ready_start_o     ( ready_start_o   ),
    .done_o            ( done_o          ),
    .gen_start_o       ( gen_start       ),
    .addr_ready_o      ( head_ready      ),
    .ofs_push_o        ( ofs_push        ),
    .ofs_data_o        ( ofs_push_data   ),
    .ofs_pop_o         ( ofs_pop         ),
    .mem_req_o         ( mem_req_o       ),
    .mem_addr_o        ( mem_addr_o      ),
    .mem_rready_o      ( mem_rready_o    ),
    .stream_valid_o    ( stream_valid_o  ),
    .stream_data_o     ( stream_data_o   )
  );

endmodule

// File: hw/strm_source.sv
/*
 * source streamer core
 * control FSM, memory read requests, byte realignment, beat counter
 */

module strm_source (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  logic                start_i,
  input  strm_pkg::len_t      line_len_i,
  input  strm_pkg::len_t      line_cnt_i,
  input  logic                gen_done_i,        // address walk finished
  input  logic                addr_valid_i,      // address FIFO head
  input  strm_pkg::addr_t     addr_i,
  input  logic                addr_fifo_empty_i,
  input  logic                ofs_ready_i,       // offset FIFO not full
  input  logic                ofs_valid_i,
  input  strm_pkg::ofs_t      ofs_i,             // offset of oldest read
  input  logic                mem_gnt_i,
  input  logic                mem_rvalid_i,
  input  strm_pkg::mem_data_t mem_rdata_i,
  input  logic                stream_ready_i,
  output logic                ready_start_o,
  output logic                done_o,
  output logic                gen_start_o,
  output logic                addr_ready_o,
  output logic                ofs_push_o,
  output strm_pkg::ofs_t      ofs_data_o,
  output logic                ofs_pop_o,
  output logic                mem_req_o,
  output strm_pkg::addr_t     mem_addr_o,
  output logic                mem_rready_o,
  output logic                stream_valid_o,
  output strm_pkg::beat_t     stream_data_o
);

  localparam int unsigned CNT_W = 2 * $bits(strm_pkg::len_t); // holds len * cnt

  strm_pkg::strm_state_t cs, ns;
  logic [CNT_W-1:0]      beat_cnt_q, total;
  logic                  issue, beat;

  assign total = CNT_W'(line_len_i) * CNT_W'(line_cnt_i);

  // FSM
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs <= strm_pkg::STRM_IDLE;
    end else if (clear_i) begin
      cs <= strm_pkg::STRM_IDLE;
    end else begin
      cs <= ns;
    end
  end

  always_comb begin
    ns     = cs;
    done_o = 1'b0;
    case (cs)
      strm_pkg::STRM_IDLE: begin
        if (start_i) ns = strm_pkg::STRM_WORKING;
      end
      strm_pkg::STRM_WORKING: begin
        if (gen_done_i) ns = strm_pkg::STRM_DRAIN;
      end
      strm_pkg::STRM_DRAIN: begin
        // all beats out and nothing left queued
        if (beat_cnt_q == total && addr_fifo_empty_i) begin
          ns     = strm_pkg::STRM_IDLE;
          done_o = 1'b1;
        end
      end
      default: ns = strm_pkg::STRM_IDLE;
    endcase
  end

  assign ready_start_o = (cs == strm_pkg::STRM_IDLE);
  assign gen_start_o   = start_i & ready_start_o; // ignored while busy

  // request side
  assign mem_req_o    = (cs != strm_pkg::STRM_IDLE) & addr_valid_i & stream_ready_i
                        & ofs_ready_i;             // room to track the offset
  assign mem_addr_o   = {addr_i[$bits(strm_pkg::addr_t)-1:2], 2'b00}; // word aligned
  assign issue        = mem_req_o & mem_gnt_i;
  assign addr_ready_o = issue;                     // pop addr on grant
  assign ofs_push_o   = issue;
  assign ofs_data_o   = addr_i[1:0];

  // response side, zero latency to the stream
  assign mem_rready_o   = stream_ready_i;
  assign stream_valid_o = mem_rvalid_i;
  assign beat           = stream_valid_o & stream_ready_i;
  assign ofs_pop_o      = beat;                    // offset retires with its response
  assign stream_data_o  = mem_rdata_i[{ofs_i, 3'b000} +: $bits(strm_pkg::beat_t)]; // realign

  // beat counter
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt_q <= '0;
    end else if (clear_i || done_o) begin
      beat_cnt_q <= '0;
    end else if (beat) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  // every response must match an issued read
  a_rvalid_tracked: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rvalid_i |-> ofs_valid_i);
  // held beat keeps its bytes, memory and offset FIFO together
  a_beat_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stream_valid_o && !stream_ready_i && !clear_i
    |=> stream_valid_o && $stable(stream_data_o));

endmodule

// File: hw/strm_addr_gen.sv
/*
 * two-level address generator
 * word stride inside a line, line stride between lines, valid/ready output
 */

module strm_addr_gen (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            clear_i,
  input  logic            start_i,        // sample config, begin walk
  input  strm_pkg::addr_t base_i,
  input  strm_pkg::len_t  word_stride_i,  // bytes
  input  strm_pkg::len_t  line_len_i,     // words per line
  input  strm_pkg::len_t  line_stride_i,  // bytes between line starts
  input  strm_pkg::len_t  line_cnt_i,
  input  logic            addr_ready_i,
  output logic            addr_valid_o,
  output strm_pkg::addr_t addr_o,
  output logic            done_o          // one cycle after last accept
);

  logic            running_q, done_q;
  strm_pkg::len_t  word_cnt_q, line_cnt_q;
  strm_pkg::addr_t line_start_q, addr_q;
  strm_pkg::addr_t next_line;
  logic            accept, last_word, last_line;

  assign accept    = running_q & addr_ready_i;
  assign last_word = (word_cnt_q == strm_pkg::len_t'(line_len_i - 1'b1));
  assign last_line = (line_cnt_q == strm_pkg::len_t'(line_cnt_i - 1'b1));
  assign next_line = line_start_q + strm_pkg::addr_t'(line_stride_i);

  assign addr_valid_o = running_q;
  assign addr_o       = addr_q;
  assign done_o       = done_q;

  // control state and counters
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q  <= 1'b0;
      done_q     <= 1'b0;
      word_cnt_q <= '0;
      line_cnt_q <= '0;
    end else if (clear_i) begin
      running_q  <= 1'b0;
      done_q     <= 1'b0;
      word_cnt_q <= '0;
      line_cnt_q <= '0;
    end else begin
      done_q <= 1'b0; // pulse
      if (start_i && !running_q) begin
        running_q  <= 1'b1;
        word_cnt_q <= '0;
        line_cnt_q <= '0;
      end else if (accept) begin
        if (!last_word) begin
          word_cnt_q <= word_cnt_q + 1'b1;
        end else if (!last_line) begin
          word_cnt_q <= '0;          // next line
          line_cnt_q <= line_cnt_q + 1'b1;
        end else begin
          running_q  <= 1'b0;        // pattern finished
          done_q     <= 1'b1;
        end
      end
    end
  end

  // address payload
  always_ff @(posedge clk_i) begin
    if (start_i && !running_q) begin
      addr_q       <= base_i;
      line_start_q <= base_i;
    end else if (accept) begin
      if (!last_word) begin
        addr_q <= addr_q + strm_pkg::addr_t'(word_stride_i);
      end else begin
        addr_q       <= next_line;
        line_start_q <= next_line;
      end
    end
  end

  a_addr_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    addr_valid_o && !addr_ready_i && !clear_i |=> addr_valid_o && $stable(addr_o));

endmodule

// File: hw/strm_fifo.sv
/*
 * synchronous FIFO with valid/ready on both sides
 * circular buffer, occupancy count, full and empty flags
 */

module strm_fifo #(
  parameter int unsigned WIDTH = 32,
  parameter int unsigned DEPTH = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,       // sync flush
  input  logic             push_valid_i,
  input  logic [WIDTH-1:0] push_data_i,
  output logic             push_ready_o,  // low when full
  output logic             pop_valid_o,
  output logic [WIDTH-1:0] pop_data_o,
  input  logic             pop_ready_i,
  output logic             empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH]; // entry storage
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             push, pop;

  assign empty_o      = (cnt_q == '0);
  assign push_ready_o = (cnt_q != CNT_W'(DEPTH));
  assign pop_valid_o  = ~empty_o;
  assign pop_data_o   = mem_q[rd_ptr_q];   // head entry

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_ready_i & pop_valid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1; // wrap
      if (pop)  rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (push && !pop)      cnt_q <= cnt_q + 1'b1;
      else if (pop && !push) cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_data_i; // visible at head next cycle
  end

  // consumer never asks for data that is not there
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_ready_i |-> !empty_o);
  // when full the write slot sits on the unread head, a push would overwrite it
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !push_ready_o |-> wr_ptr_q == rd_ptr_q);

endmodule

// File: hw/strm_pkg.sv
/*
 * streamer package
 * vector typedefs for addresses, data, lengths, offsets and the FSM state
 */

`include "strm_cfg.svh"

package strm_pkg;

  typedef logic [`STRM_ADDR_W-1:0]    addr_t;     // byte address
  typedef logic [`STRM_MEM_DW-1:0]    mem_data_t; // byte k = mem[aligned + k]
  typedef logic [`STRM_STREAM_DW-1:0] beat_t;     // output beat
  typedef logic [`STRM_LEN_W-1:0]     len_t;      // length, count or stride
  typedef logic [1:0]                 ofs_t;      // byte offset in a word

  // source controller states
  typedef enum logic [1:0] {
    STRM_IDLE    = 2'd0,
    STRM_WORKING = 2'd1, // generator still producing addresses
    STRM_DRAIN   = 2'd2  // waiting for the last beats
  } strm_state_t;

endpackage

// File: include/strm_cfg.svh
/*
 * streamer configuration macros
 * widths of addresses, data and lengths, FIFO depths
 */

`ifndef STRM_CFG_SVH
`define STRM_CFG_SVH

`define STRM_ADDR_W          32 // byte address
`define STRM_STREAM_DW       32 // one stream beat
`define STRM_MEM_DW          64 // stream width plus one word for realignment
`define STRM_LEN_W           16 // lengths, counts and strides

`define STRM_ADDR_FIFO_DEPTH 2  // address decoupling
`define STRM_OFS_DEPTH       4  // max reads in flight

`endif
